/* project.f */
lspcPkg.sv
lspcRegs.sv
vramPort.sv
vramArray.sv
videoCounters.sv
autoAnim.sv
lspcTop.sv
tbLspc.sv

/* tbLspc.sv */
`timescale 1ns/1ps

module tbLspc;
	import lspcPkg::*;

	localparam int tbPixels = 24;
	localparam int tbLines = 12;
	localparam int tbHSync = 4;
	localparam int tbVSync = 2;

	// One pending read check
	typedef struct packed {
		logic [31:0] due;
		cpuAddr_t addr;
		cpuWord_t expData;
	} readCheck_t;

	logic CLK;
	logic nRESETP;
	cpuBus_t cpuBus;
	cpuWord_t rdData;
	logic hSync;
	logic vSync;

	logic [31:0] cycle = '0;
	logic [31:0] rngState;
	readCheck_t pending [$];

	// ==================================================================
	// Model state
	// ==================================================================

	cpuWord_t shadowMem [vramAddr_t];
	vramAddr_t shadowAddr;
	vramAddr_t shadowMod;
	cpuWord_t shadowLatch;
	aaSpeed_t shadowSpeed;
	aaCount_t tileBase;
	int vFalls;
	int vFallsSinceMode;
	int hFallsInFrame;
	int sinceHFall;
	logic [31:0] lastVFall;
	logic [31:0] lastHFall;
	logic hFallSeen;
	logic prevV;
	logic prevH;

	lspcTop #(
		.pixelsPerLine(tbPixels),
		.linesPerFrame(tbLines),
		.hSyncPixels(tbHSync),
		.vSyncLines(tbVSync)
	) lspcTop_i (
		.CLK(CLK),
		.nRESETP(nRESETP),
		.cpuBus(cpuBus),
		.rdData(rdData),
		.hSync(hSync),
		.vSync(vSync)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycle <= cycle + 1;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic cpuWord_t randWord();
		rngState = xorshift(rngState);
		return rngState[15:0];
	endfunction

	// Unwritten words are unknown in the RAM too
	function automatic cpuWord_t peekShadow(input vramAddr_t a);
		return shadowMem.exists(a) ? shadowMem[a] : 'x;
	endfunction

	// One tile step per speed + 1 frames since the last mode write
	function automatic aaCount_t modelTile(input aaCount_t base, input int frames,
			input aaSpeed_t speed);
		return aaCount_t'((int'(base) + frames / (int'(speed) + 1)) % 8);
	endfunction

	// Expected read word for one register
	function automatic cpuWord_t expectedRead(input cpuAddr_t addr, input cpuWord_t latch,
			input vramAddr_t modulo, input aaSpeed_t speed, input aaCount_t base,
			input int frames, input int linesSeen);
		raster_t raster;
		raster = raster_t'((linesSeen + tbLines - 1) % tbLines);
		case (addr)
			regVramAddr: return latch;
			regVramRw: return latch;
			regVramMod: return modulo;
			regLspcMode: return {raster, 4'b0000, modelTile(base, frames, speed)};
			default: return '0;
		endcase
	endfunction

	task automatic failRun();
		$display("Done: errors found");
		$fatal(1, "Simulation stopped");
	endtask

	// ==================================================================
	// Sync monitor and period checks
	// ==================================================================

	always @(negedge CLK) begin
		if (nRESETP) begin
			sinceHFall = sinceHFall + 1;
			// Low time of each sync pulse
			if (!prevV && vSync && vFalls > 0) begin
				assert (cycle - lastVFall == tbPixels * tbVSync) else begin
					$display("ERROR %0t vSync low cycles expected %0d got %0d", $time,
						tbPixels * tbVSync, cycle - lastVFall);
					failRun();
				end
			end
			if (!prevH && hSync && hFallSeen) begin
				assert (cycle - lastHFall == tbHSync) else begin
					$display("ERROR %0t hSync low cycles expected %0d got %0d", $time,
						tbHSync, cycle - lastHFall);
					failRun();
				end
			end
			if (prevV && !vSync) begin
				if (vFalls > 0) begin
					assert (cycle - lastVFall == tbPixels * tbLines) else begin
						$display("ERROR %0t vSync period expected %0d got %0d", $time,
							tbPixels * tbLines, cycle - lastVFall);
						failRun();
					end
				end
				vFalls = vFalls + 1;
				vFallsSinceMode = vFallsSinceMode + 1;
				lastVFall = cycle;
				hFallsInFrame = 0;
			end
			// Coincident hSync fall counts as line 0
			if (prevH && !hSync) begin
				if (hFallSeen) begin
					assert (cycle - lastHFall == tbPixels) else begin
						$display("ERROR %0t hSync period expected %0d got %0d", $time,
							tbPixels, cycle - lastHFall);
						failRun();
					end
				end
				hFallSeen = 1'b1;
				lastHFall = cycle;
				hFallsInFrame = hFallsInFrame + 1;
				sinceHFall = 0;
			end
			prevV = vSync;
			prevH = hSync;
		end
	end

	// Read checks, two cycles after the sampling edge
	always @(negedge CLK) begin : compareReads
		readCheck_t head;
		if (pending.size() > 0) begin
			head = pending[0];
			if (head.due == cycle) begin
				void'(pending.pop_front());
				assert (rdData === head.expData) else begin
					$display("ERROR %0t rdData reg %0d expected %h got %h", $time,
						head.addr, head.expData, rdData);
					failRun();
				end
			end
		end
	end

	// ==================================================================
	// CPU bus tasks
	// ==================================================================

	task automatic writeReg(input cpuAddr_t addr, input cpuWord_t data);
		@(posedge CLK);
		cpuBus <= '{addr: addr, wrData: data, rd: 1'b0, wr: 1'b1};
		case (addr)
			regVramAddr: begin
				shadowAddr = data;
				shadowLatch = peekShadow(shadowAddr);
			end
			regVramRw: begin
				shadowMem[shadowAddr] = data;
				shadowAddr = shadowAddr + shadowMod;
				shadowLatch = peekShadow(shadowAddr);
			end
			regVramMod: shadowMod = data;
			// New speed restarts the frame divider
			regLspcMode: begin
				tileBase = modelTile(tileBase, vFallsSinceMode, shadowSpeed);
				vFallsSinceMode = 0;
				shadowSpeed = data[15:8];
			end
			default: ;
		endcase
		@(posedge CLK);
		cpuBus.wr <= 1'b0;
		repeat (4) @(posedge CLK);
	endtask

	task automatic readReg(input cpuAddr_t addr);
		readCheck_t chk;
		@(posedge CLK);
		cpuBus <= '{addr: addr, wrData: '0, rd: 1'b1, wr: 1'b0};
		// Model now holds the strobe-cycle state
		@(posedge CLK);
		cpuBus.rd <= 1'b0;
		chk.due = cycle + 2;
		chk.addr = addr;
		chk.expData = expectedRead(addr, shadowLatch, shadowMod, shadowSpeed, tileBase,
			vFallsSinceMode, hFallsInFrame);
		pending.push_back(chk);
		repeat (4) @(posedge CLK);
	endtask

	task automatic waitVSyncFall();
		int start;
		int waited;
		start = vFalls;
		waited = 0;
		while (vFalls == start) begin
			@(posedge CLK);
			waited++;
			if (waited > 2 * tbPixels * tbLines) begin
				$display("Timeout while waiting for a vSync fall");
				failRun();
			end
		end
	endtask

	// Keeps mode reads clear of the raster step before each hSync fall
	task automatic waitReadWindow();
		int waited;
		waited = 0;
		while (sinceHFall < 2 || sinceHFall > 16) begin
			@(posedge CLK);
			waited++;
			if (waited > 2 * tbPixels) begin
				$display("Timeout while waiting for a read window on the line");
				failRun();
			end
		end
	endtask

	task automatic waitDrain();
		int waited;
		waited = 0;
		while (pending.size() > 0) begin
			@(posedge CLK);
			waited++;
			if (waited > 10) begin
				$display("Timeout while pending read checks were left unchecked");
				failRun();
			end
		end
	endtask

	// ==================================================================
	// Stimulus
	// ==================================================================

	initial begin
		vramAddr_t base;
		cpuWord_t speedWord;
		int i;
		nRESETP = 1'b0;
		cpuBus = '0;
		rngState = 32'h572af3a7;
		shadowAddr = '0;
		shadowMod = '0;
		shadowLatch = '0;
		shadowSpeed = '0;
		tileBase = '0;
		vFalls = 0;
		vFallsSinceMode = 0;
		hFallsInFrame = 0;
		sinceHFall = 0;
		lastVFall = '0;
		lastHFall = '0;
		hFallSeen = 1'b0;
		prevV = 1'b0;
		prevH = 1'b0;
		repeat (5) @(posedge CLK);
		nRESETP <= 1'b1;

		// Reset values
		readReg(regVramMod);
		readReg(regVramAddr);

		// Fill eight words along the modulo
		writeReg(regVramMod, randWord());
		base = randWord();
		writeReg(regVramAddr, base);
		for (i = 0; i < 8; i++) begin
			writeReg(regVramRw, randWord());
		end

		// Walk back over them, write-back steps the address
		writeReg(regVramAddr, base);
		for (i = 0; i < 8; i++) begin
			readReg(regVramRw);
			readReg(regVramAddr);
			if (i < 7) begin
				writeReg(regVramRw, shadowMem[shadowAddr]);
			end
		end
		writeReg(regVramMod, randWord());
		readReg(regVramMod);

		// Tile and raster with speed 0
		waitVSyncFall();
		for (i = 0; i < 48; i++) begin
			waitReadWindow();
			readReg(regLspcMode);
			repeat (40 + randWord() % 30) @(posedge CLK);
		end

		// Speed 2, one tile step per three frames
		waitVSyncFall();
		speedWord = randWord();
		speedWord[15:8] = 8'd2;
		writeReg(regLspcMode, speedWord);
		for (i = 0; i < 48; i++) begin
			waitReadWindow();
			readReg(regLspcMode);
			repeat (40 + randWord() % 30) @(posedge CLK);
		end
		waitDrain();

		if (vFalls >= 16) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("Too few frames were seen for the tile and period checks");
			failRun();
		end
	end

endmodule

/* lspcTop.sv */
`timescale 1ns/1ps

module lspcTop #(
	parameter int pixelsPerLine = 384,
	parameter int linesPerFrame = 264,
	parameter int hSyncPixels = 32,
	parameter int vSyncLines = 8
) (
	input logic CLK,
	input logic nRESETP,
	input lspcPkg::cpuBus_t cpuBus,
	output lspcPkg::cpuWord_t rdData,
	output logic hSync,
	output logic vSync
);
	import lspcPkg::*;

	// Register block and VRAM port
	vramCmd_t vramCmd;
	vramAddr_t vramMod;
	cpuWord_t readAhead;

	// VRAM port and RAM
	vramAddr_t memAddr;
	logic memWe;
	cpuWord_t memWrData;
	cpuWord_t memRdData;

	// Timing and animation
	videoStatus_t videoStatus;
	aaSpeed_t aaSpeed;
	logic aaRestart;
	aaCount_t aaCount;

	// ==================================================================
	// CPU side
	// ==================================================================

	lspcRegs lspcRegs_i (
		.CLK(CLK),
		.nRESETP(nRESETP),
		.cpuBus(cpuBus),
		.videoStatus(videoStatus),
		.aaCount(aaCount),
		.readAhead(readAhead),
		.vramCmd(vramCmd),
		.vramMod(vramMod),
		.aaSpeed(aaSpeed),
		.aaRestart(aaRestart),
		.rdData(rdData)
	);

	vramPort vramPort_i (
		.CLK(CLK),
		.nRESETP(nRESETP),
		.vramCmd(vramCmd),
		.vramMod(vramMod),
		.memAddr(memAddr),
		.memWe(memWe),
		.memWrData(memWrData),
		.memRdData(memRdData),
		.readAhead(readAhead)
	);

	vramArray vramArray_i (
		.CLK(CLK),
		.addr(memAddr),
		.we(memWe),
		.wrData(memWrData),
		.rdData(memRdData)
	);

	// ==================================================================
	// Video timing
	// ==================================================================

	videoCounters #(
		.pixelsPerLine(pixelsPerLine),
		.linesPerFrame(linesPerFrame),
		.hSyncPixels(hSyncPixels),
		.vSyncLines(vSyncLines)
	) videoCounters_i (
		.CLK(CLK),
		.nRESETP(nRESETP),
		.videoStatus(videoStatus),
		.hSync(hSync),
		.vSync(vSync)
	);

	// Tile counter steps on frame starts
	autoAnim autoAnim_i (
		.CLK(CLK),
		.nRESETP(nRESETP),
		.frameStart(videoStatus.frameStart),
		.aaSpeed(aaSpeed),
		.aaRestart(aaRestart),
		.aaCount(aaCount)
	);

endmodule

/* autoAnim.sv */
`timescale 1ns/1ps

module autoAnim (
	input logic CLK,
	input logic nRESETP,
	input logic frameStart,
	input lspcPkg::aaSpeed_t aaSpeed,
	input logic aaRestart,
	output lspcPkg::aaCount_t aaCount
);
	import lspcPkg::*;

	// Frames seen since the last tile step
	aaSpeed_t frameDiv;

	// One tile step every aaSpeed + 1 frames
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			frameDiv <= '0;
			aaCount <= '0;
		end else if (aaRestart) begin
			// New speed written, start the period over
			frameDiv <= '0;
		end else if (frameStart) begin
			if (frameDiv == aaSpeed) begin
				frameDiv <= '0;
				// Wraps modulo 8
				aaCount <= aaCount + 1'b1;
			end else begin
				frameDiv <= frameDiv + 1'b1;
			end
		end
	end

endmodule

/* videoCounters.sv */
`timescale 1ns/1ps

module videoCounters #(
	parameter int pixelsPerLine = 384,
	parameter int linesPerFrame = 264,
	parameter int hSyncPixels = 32,
	parameter int vSyncLines = 8
) (
	input logic CLK,
	input logic nRESETP,
	output lspcPkg::videoStatus_t videoStatus,
	output logic hSync,
	output logic vSync
);
	import lspcPkg::*;

	// Counter limits in counter width
	localparam pixelCount_t lastPixel = pixelCount_t'(pixelsPerLine - 1);
	localparam raster_t lastLine = raster_t'(linesPerFrame - 1);
	localparam pixelCount_t hSyncEnd = pixelCount_t'(hSyncPixels);
	localparam raster_t vSyncEnd = raster_t'(vSyncLines);

	pixelCount_t pixel;
	raster_t raster;

	// Last pixel of a line, last pixel of a frame
	logic lineEnd;
	logic frameEnd;

	logic lineStart;
	logic frameStart;

	assign lineEnd = (pixel == lastPixel);
	assign frameEnd = lineEnd && (raster == lastLine);

	// ==================================================================
	// Pixel and raster counters
	// ==================================================================

	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			pixel <= '0;
			raster <= '0;
		end else if (lineEnd) begin
			pixel <= '0;
			// Raster steps together with the pixel wrap
			if (frameEnd) begin
				raster <= '0;
			end else begin
				raster <= raster + 1'b1;
			end
		end else begin
			pixel <= pixel + 1'b1;
		end
	end

	// Pulses high while pixel is back at zero
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			lineStart <= 1'b0;
			frameStart <= 1'b0;
		end else begin
			lineStart <= lineEnd;
			frameStart <= frameEnd;
		end
	end

	// ==================================================================
	// Sync outputs
	// ==================================================================

	// Active low, one cycle behind the counters
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			hSync <= 1'b0;
			vSync <= 1'b0;
		end else begin
			hSync <= (pixel >= hSyncEnd);
			vSync <= (raster >= vSyncEnd);
		end
	end

	assign videoStatus = '{raster: raster, lineStart: lineStart, frameStart: frameStart};

endmodule

/* vramArray.sv */
`timescale 1ns/1ps

module vramArray (
	input logic CLK,
	input lspcPkg::vramAddr_t addr,
	input logic we,
	input lspcPkg::cpuWord_t wrData,
	output lspcPkg::cpuWord_t rdData
);
	import lspcPkg::*;

	// Full 16-bit address space
	localparam int depth = 2 ** $bits(vramAddr_t);

	cpuWord_t mem [0:depth-1];

	// Single port
	// write when we is set, read every cycle
	always_ff @(posedge CLK) begin
		if (we) begin
			mem[addr] <= wrData;
		end
		rdData <= mem[addr];
	end

endmodule

/* vramPort.sv */
`timescale 1ns/1ps

module vramPort (
	input logic CLK,
	input logic nRESETP,
	input lspcPkg::vramCmd_t vramCmd,
	input lspcPkg::vramAddr_t vramMod,
	output lspcPkg::vramAddr_t memAddr,
	output logic memWe,
	output lspcPkg::cpuWord_t memWrData,
	input lspcPkg::cpuWord_t memRdData,
	output lspcPkg::cpuWord_t readAhead
);
	import lspcPkg::*;

	// Current CPU-side VRAM address
	vramAddr_t vramAddr;

	// Any command that moves the address
	logic addrMove;

	// Read-ahead pipeline
	// readIssue is high while the new address sits on the RAM
	// readBack is high while its data sits on memRdData
	logic readIssue;
	logic readBack;

	// ==================================================================
	// Address register
	// ==================================================================

	assign addrMove = vramCmd.loadAddr | vramCmd.writeData;

	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			vramAddr <= '0;
		end else if (vramCmd.loadAddr) begin
			vramAddr <= vramCmd.data;
		end else if (vramCmd.writeData) begin
			// Auto-increment after the write, wraps at 64K words
			vramAddr <= vramAddr + vramMod;
		end
	end

	// ==================================================================
	// RAM interface
	// ==================================================================

	// Write goes to the old address, in the command cycle
	assign memAddr = vramAddr;
	assign memWe = vramCmd.writeData;
	assign memWrData = vramCmd.data;

	// ==================================================================
	// Read-ahead latch
	// ==================================================================

	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			readIssue <= 1'b0;
			readBack <= 1'b0;
		end else begin
			readIssue <= addrMove;
			readBack <= readIssue;
		end
	end

	// Three cycles after the CPU strobe
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			readAhead <= '0;
		end else if (readBack) begin
			readAhead <= memRdData;
		end
	end

endmodule

/* lspcRegs.sv */
`timescale 1ns/1ps

module lspcRegs (
	input logic CLK,
	input logic nRESETP,
	input lspcPkg::cpuBus_t cpuBus,
	input lspcPkg::videoStatus_t videoStatus,
	input lspcPkg::aaCount_t aaCount,
	input lspcPkg::cpuWord_t readAhead,
	output lspcPkg::vramCmd_t vramCmd,
	output lspcPkg::vramAddr_t vramMod,
	output lspcPkg::aaSpeed_t aaSpeed,
	output logic aaRestart,
	output lspcPkg::cpuWord_t rdData
);
	import lspcPkg::*;

	// Decoded write strobes
	logic wrVramAddr;
	logic wrVramRw;
	logic wrVramMod;
	logic wrLspcMode;

	// Mode register as seen by the CPU
	cpuWord_t modeWord;

	// Read word, selected in the strobe cycle
	cpuWord_t rdMux;

	// ==================================================================
	// Strobe decode
	// ==================================================================

	assign wrVramAddr = cpuBus.wr && (cpuBus.addr == regVramAddr);
	assign wrVramRw = cpuBus.wr && (cpuBus.addr == regVramRw);
	assign wrVramMod = cpuBus.wr && (cpuBus.addr == regVramMod);
	assign wrLspcMode = cpuBus.wr && (cpuBus.addr == regLspcMode);

	// VRAM commands, one cycle behind the strobe
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			vramCmd <= '0;
		end else begin
			vramCmd.loadAddr <= wrVramAddr;
			vramCmd.writeData <= wrVramRw;
			// Address or data, the port tells them apart by the pulse
			vramCmd.data <= cpuBus.wrData;
		end
	end

	// ==================================================================
	// Modulo and mode registers
	// ==================================================================

	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			vramMod <= vramModReset;
		end else if (wrVramMod) begin
			vramMod <= cpuBus.wrData;
		end
	end

	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			aaSpeed <= aaSpeedReset;
			aaRestart <= 1'b0;
		end else begin
			// Restart pulse lines up with the new speed
			aaRestart <= wrLspcMode;
			if (wrLspcMode) begin
				aaSpeed <= cpuBus.wrData[modeSpeedLsb +: $bits(aaSpeed_t)];
			end
		end
	end

	// ==================================================================
	// Read path
	// ==================================================================

	// Raster on top, tile number at the bottom
	assign modeWord = {videoStatus.raster, 4'b0000, aaCount};

	always_comb begin
		case (cpuBus.addr)
			regVramAddr: rdMux = readAhead;
			regVramRw: rdMux = readAhead;
			regVramMod: rdMux = vramMod;
			regLspcMode: rdMux = modeWord;
			// Unused words read as zero
			default: rdMux = '0;
		endcase
	end

	// Held until the next rd
	always_ff @(posedge CLK or negedge nRESETP) begin
		if (!nRESETP) begin
			rdData <= '0;
		end else if (cpuBus.rd) begin
			rdData <= rdMux;
		end
	end

endmodule

/* lspcPkg.sv */
package lspcPkg;

	// ==================================================================
	// Widths with a meaning
	// ==================================================================

	// Word offset inside the CPU register window
	typedef logic [2:0] cpuAddr_t;

	// CPU data word
	typedef logic [15:0] cpuWord_t;

	// Video RAM word address
	typedef logic [15:0] vramAddr_t;

	// Horizontal pixel position
	typedef logic [8:0] pixelCount_t;

	// Raster line number
	typedef logic [8:0] raster_t;

	// Auto-animation frame divisor
	typedef logic [7:0] aaSpeed_t;

	// Auto-animation tile number
	typedef logic [2:0] aaCount_t;

	// ==================================================================
	// Register map and reset values
	// ==================================================================

	localparam cpuAddr_t regVramAddr = 3'd0;
	localparam cpuAddr_t regVramRw = 3'd1;
	localparam cpuAddr_t regVramMod = 3'd2;
	localparam cpuAddr_t regLspcMode = 3'd3;

	// Speed field sits in the upper byte of the mode word
	localparam int modeSpeedLsb = 8;

	localparam vramAddr_t vramModReset = '0;
	localparam aaSpeed_t aaSpeedReset = '0;

	// ==================================================================
	// Bundles
	// ==================================================================

	// CPU side, one-cycle strobes
	typedef struct packed {
		cpuAddr_t addr;
		cpuWord_t wrData;
		logic rd;
		logic wr;
	} cpuBus_t;

	// Register block to VRAM port
	typedef struct packed {
		logic loadAddr;
		logic writeData;
		cpuWord_t data;
	} vramCmd_t;

	// Raster position and timing pulses
	typedef struct packed {
		raster_t raster;
		logic lineStart;
		logic frameStart;
	} videoStatus_t;

endpackage
